// ==== dma_defines.svh ====
/*
 * cluster DMA global parameters
 * widths, cluster memory window and queue depth
 */

`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// bus widths
`define DMA_DATA_W        32
`define DMA_ADDR_W        32
`define DMA_LEN_W         16

// cluster window, base of cluster 0 and stride per cluster id
`define DMA_CLUSTER_BASE  32'h1000_0000
`define DMA_CLUSTER_SHIFT 22
`define DMA_TCDM_SIZE     32'h0010_0000

`define DMA_QUEUE_DEPTH   4

`endif

// ==== dma_ctrl_pkg.sv ====
/*
 * cluster DMA control-side types
 * register port, register map and transfer descriptors
 */

`include "dma_defines.svh"

package dma_ctrl_pkg;

  // core access to the register port, wen high for a write
  typedef struct packed {
    logic                   req;
    logic                   wen;
    logic [7:0]             add;
    logic [`DMA_DATA_W-1:0] wdata;
  } ctrl_req_t;

  typedef struct packed {
    logic                   gnt;
    logic                   r_valid;
    logic [`DMA_DATA_W-1:0] r_rdata;
  } ctrl_rsp_t;

  typedef enum logic [7:0] {
    REG_SRC    = 8'h00,
    REG_DST    = 8'h04,
    REG_LEN    = 8'h08,
    REG_CMD    = 8'h0C,
    REG_STATUS = 8'h10
  } ctrl_reg_e;

  // one queued copy, len counts 32-bit words
  typedef struct packed {
    logic [`DMA_ADDR_W-1:0] src;
    logic [`DMA_ADDR_W-1:0] dst;
    logic [`DMA_LEN_W-1:0]  len;
  } transf_descr_t;

endpackage

// ==== dma_bus_pkg.sv ====
/*
 * cluster DMA memory-side types
 * engine accesses, TCDM port and AXI4-Lite channels
 */

`include "dma_defines.svh"

package dma_bus_pkg;

  // single word access issued by the engine
  typedef struct packed {
    logic [`DMA_ADDR_W-1:0] addr;
    logic                   we;
    logic [`DMA_DATA_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [`DMA_DATA_W-1:0] rdata;
  } mem_rsp_t;

  // wen is active low here, same as the cluster TCDM
  typedef struct packed {
    logic                     req;
    logic                     wen;
    logic [`DMA_ADDR_W-1:0]   add;
    logic [`DMA_DATA_W-1:0]   wdata;
    logic [`DMA_DATA_W/8-1:0] be;
  } tcdm_req_t;

  typedef struct packed {
    logic                     aw_valid;
    logic [`DMA_ADDR_W-1:0]   aw_addr;
    logic [2:0]               aw_prot;
    logic                     w_valid;
    logic [`DMA_DATA_W-1:0]   w_data;
    logic [`DMA_DATA_W/8-1:0] w_strb;
    logic                     b_ready;
    logic                     ar_valid;
    logic [`DMA_ADDR_W-1:0]   ar_addr;
    logic [2:0]               ar_prot;
    logic                     r_ready;
  } axil_req_t;

  typedef struct packed {
    logic                   aw_ready;
    logic                   w_ready;
    logic                   b_valid;
    logic                   ar_ready;
    logic                   r_valid;
    logic [`DMA_DATA_W-1:0] r_data;
  } axil_rsp_t;

endpackage

// ==== dma_fifo.sv ====
/*
 * small circular FIFO with a count
 * payload type is a parameter
 */

`timescale 1ns/100ps

module dma_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 4
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_valid_i,
  output logic     push_ready_o,
  input  payload_t push_data_i,
  output logic     pop_valid_o,
  input  logic     pop_ready_i,
  output payload_t pop_data_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             push, pop;

  assign push_ready_o = (count_q < DEPTH);
  assign pop_valid_o  = (count_q != '0);
  assign push         = push_valid_i & push_ready_o;
  assign pop          = pop_valid_o & pop_ready_i;
  assign pop_data_o   = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + push - pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // the producer watches ready itself and never offers data into a full buffer
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(push_valid_i && (count_q == DEPTH)));

endmodule

// ==== dma_ctrl_regs.sv ====
/*
 * cluster DMA control registers
 * staging registers, command queue with back-pressure and status
 */

`timescale 1ns/100ps
`include "dma_defines.svh"

module dma_ctrl_regs import dma_ctrl_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  ctrl_req_t     ctrl_req_i,
  output ctrl_rsp_t     ctrl_rsp_o,
  output logic          descr_valid_o,
  input  logic          descr_ready_i,
  output transf_descr_t descr_o,
  input  logic          xfer_done_i,
  input  logic          engine_busy_i,
  output logic          busy_o
);

  logic [`DMA_ADDR_W-1:0] src_q, dst_q;
  logic [`DMA_LEN_W-1:0]  len_q;
  logic [7:0]             done_cnt_q;
  logic                   rvalid_q;
  logic [`DMA_DATA_W-1:0] rdata_q, rd_val;
  logic                   is_cmd, gnt, queue_ready;
  transf_descr_t          descr_in;

  // command writes stall while the queue is full
  assign is_cmd = ctrl_req_i.wen && (ctrl_req_i.add == REG_CMD);
  assign gnt    = ctrl_req_i.req && (!is_cmd || queue_ready);

  assign descr_in = '{src: src_q, dst: dst_q, len: len_q};
  assign busy_o   = descr_valid_o | engine_busy_i;

  always_comb begin
    case (ctrl_req_i.add)
      REG_SRC:    rd_val = src_q;
      REG_DST:    rd_val = dst_q;
      REG_LEN:    rd_val = `DMA_DATA_W'(len_q);
      REG_STATUS: rd_val = {{(`DMA_DATA_W-16){1'b0}}, done_cnt_q, 7'b0, busy_o};
      default:    rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      src_q      <= '0;
      dst_q      <= '0;
      len_q      <= '0;
      done_cnt_q <= '0;
      rvalid_q   <= 1'b0;
    end else begin
      rvalid_q <= gnt;
      if (xfer_done_i) begin
        done_cnt_q <= done_cnt_q + 1'b1;
      end
      if (gnt && ctrl_req_i.wen) begin
        case (ctrl_req_i.add)
          REG_SRC: src_q <= ctrl_req_i.wdata;
          REG_DST: dst_q <= ctrl_req_i.wdata;
          REG_LEN: len_q <= ctrl_req_i.wdata[`DMA_LEN_W-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt && !ctrl_req_i.wen) begin
      rdata_q <= rd_val;
    end
  end

  assign ctrl_rsp_o = '{gnt: gnt, r_valid: rvalid_q, r_rdata: rdata_q};

  dma_fifo #(
    .payload_t ( transf_descr_t   ),
    .DEPTH     ( `DMA_QUEUE_DEPTH )
  ) i_descr_fifo (
    .clk_i        ( clk_i         ),
    .rst_ni       ( rst_ni        ),
    .push_valid_i ( gnt && is_cmd ),
    .push_ready_o ( queue_ready   ),
    .push_data_i  ( descr_in      ),
    .pop_valid_o  ( descr_valid_o ),
    .pop_ready_i  ( descr_ready_i ),
    .pop_data_o   ( descr_o       )
  );

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ctrl_rsp_o.r_valid |-> $past(ctrl_rsp_o.gnt));

endmodule

// ==== dma_xfer_engine.sv ====
/*
 * cluster DMA transfer engine
 * copies one word at a time, read then write, one access in flight
 */

`timescale 1ns/100ps
`include "dma_defines.svh"

module dma_xfer_engine import dma_ctrl_pkg::*; import dma_bus_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          descr_valid_i,
  output logic          descr_ready_o,
  input  transf_descr_t descr_i,
  output logic          mem_valid_o,
  input  logic          mem_ready_i,
  output mem_req_t      mem_req_o,
  input  logic          rsp_valid_i,
  input  mem_rsp_t      rsp_i,
  output logic          busy_o,
  output logic          done_o
);

  typedef enum logic [2:0] {IDLE, RD, RD_WAIT, WR, WR_WAIT} state_e;

  state_e                 state_q;
  logic [`DMA_ADDR_W-1:0] src_q, dst_q;
  logic [`DMA_LEN_W-1:0]  remain_q;
  logic                   done_q;
  logic                   word_space, word_valid;
  logic [`DMA_DATA_W-1:0] word;

  assign descr_ready_o = (state_q == IDLE);
  assign busy_o        = (state_q != IDLE);
  assign done_o        = done_q;

  // reads wait for room in the word buffer, writes for a buffered word
  assign mem_valid_o = ((state_q == RD) && word_space) || ((state_q == WR) && word_valid);
  assign mem_req_o   = '{addr:  (state_q == WR) ? dst_q : src_q,
                         we:    (state_q == WR),
                         wdata: word};

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      src_q    <= '0;
      dst_q    <= '0;
      remain_q <= '0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (descr_valid_i) begin
            if (descr_i.len == '0) begin
              // nothing to move
              done_q <= 1'b1;
            end else begin
              src_q    <= descr_i.src;
              dst_q    <= descr_i.dst;
              remain_q <= descr_i.len;
              state_q  <= RD;
            end
          end
        end
        RD: if (mem_valid_o && mem_ready_i) state_q <= RD_WAIT;
        RD_WAIT: begin
          if (rsp_valid_i) begin
            src_q   <= src_q + `DMA_ADDR_W'(4);
            state_q <= WR;
          end
        end
        WR: if (mem_valid_o && mem_ready_i) state_q <= WR_WAIT;
        WR_WAIT: begin
          if (rsp_valid_i) begin
            dst_q    <= dst_q + `DMA_ADDR_W'(4);
            remain_q <= remain_q - 1'b1;
            if (remain_q == `DMA_LEN_W'(1)) begin
              done_q  <= 1'b1;
              state_q <= IDLE;
            end else begin
              state_q <= RD;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  dma_fifo #(
    .payload_t ( logic [`DMA_DATA_W-1:0] ),
    .DEPTH     ( 2                       )
  ) i_word_fifo (
    .clk_i        ( clk_i                                ),
    .rst_ni       ( rst_ni                               ),
    .push_valid_i ( (state_q == RD_WAIT) && rsp_valid_i  ),
    .push_ready_o ( word_space                           ),
    .push_data_i  ( rsp_i.rdata                          ),
    .pop_valid_o  ( word_valid                           ),
    .pop_ready_i  ( (state_q == WR) && mem_ready_i       ),
    .pop_data_o   ( word                                 )
  );

endmodule

// ==== dma_addr_router.sv ====
/*
 * cluster DMA address router
 * steers accesses to the local TCDM window or to the SoC
 */

`timescale 1ns/100ps
`include "dma_defines.svh"

module dma_addr_router import dma_bus_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [5:0]             cluster_id_i,
  input  logic                   mem_valid_i,
  output logic                   mem_ready_o,
  input  mem_req_t               mem_req_i,
  output logic                   rsp_valid_o,
  output mem_rsp_t               rsp_o,
  output tcdm_req_t              tcdm_req_o,
  input  logic                   tcdm_gnt_i,
  input  logic [`DMA_DATA_W-1:0] tcdm_rdata_i,
  output logic                   soc_valid_o,
  input  logic                   soc_ready_i,
  output mem_req_t               soc_req_o,
  input  logic                   soc_rsp_valid_i,
  input  mem_rsp_t               soc_rsp_i
);

  logic [`DMA_ADDR_W-1:0] win_base;
  logic                   in_win, free;
  logic                   inflight_q, owner_tcdm_q, tcdm_rvalid_q;

  // window of this cluster, moved by the cluster id
  assign win_base = `DMA_CLUSTER_BASE + (`DMA_ADDR_W'(cluster_id_i) << `DMA_CLUSTER_SHIFT);
  assign in_win   = (mem_req_i.addr - win_base) < `DMA_TCDM_SIZE;
  assign free     = !inflight_q;

  assign tcdm_req_o = '{req:   mem_valid_i && free && in_win,
                        wen:   !mem_req_i.we,
                        add:   mem_req_i.addr,
                        wdata: mem_req_i.wdata,
                        be:    '1};
  assign soc_valid_o = mem_valid_i && free && !in_win;
  assign soc_req_o   = mem_req_i;
  assign mem_ready_o = free && (in_win ? tcdm_gnt_i : soc_ready_i);

  // completion comes from whichever target took the access
  assign rsp_valid_o = inflight_q && (owner_tcdm_q ? tcdm_rvalid_q : soc_rsp_valid_i);
  assign rsp_o.rdata = owner_tcdm_q ? tcdm_rdata_i : soc_rsp_i.rdata;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      inflight_q    <= 1'b0;
      owner_tcdm_q  <= 1'b0;
      tcdm_rvalid_q <= 1'b0;
    end else begin
      // TCDM data is valid one cycle after req and gnt
      tcdm_rvalid_q <= tcdm_req_o.req & tcdm_gnt_i;
      if (mem_valid_i && mem_ready_o) begin
        inflight_q   <= 1'b1;
        owner_tcdm_q <= in_win;
      end else if (rsp_valid_o) begin
        inflight_q <= 1'b0;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(tcdm_req_o.req && soc_valid_o));

endmodule

// ==== dma_soc_axil_master.sv ====
/*
 * cluster DMA SoC master
 * turns single word accesses into AXI4-Lite transactions
 */

`timescale 1ns/100ps

module dma_soc_axil_master import dma_bus_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  mem_req_t  req_i,
  output logic      rsp_valid_o,
  output mem_rsp_t  rsp_o,
  output axil_req_t axil_req_o,
  input  axil_rsp_t axil_rsp_i
);

  typedef enum logic [1:0] {IDLE, ADDR, RESP} state_e;

  state_e   state_q;
  mem_req_t req_q;
  logic     aw_done_q, w_done_q;
  logic     aw_hs, w_hs, ar_hs;

  assign req_ready_o = (state_q == IDLE);

  assign axil_req_o.ar_valid = (state_q == ADDR) && !req_q.we;
  assign axil_req_o.aw_valid = (state_q == ADDR) && req_q.we && !aw_done_q;
  assign axil_req_o.w_valid  = (state_q == ADDR) && req_q.we && !w_done_q;
  assign axil_req_o.ar_addr  = req_q.addr;
  assign axil_req_o.aw_addr  = req_q.addr;
  assign axil_req_o.ar_prot  = 3'b000;
  assign axil_req_o.aw_prot  = 3'b000;
  assign axil_req_o.w_data   = req_q.wdata;
  assign axil_req_o.w_strb   = '1;
  assign axil_req_o.r_ready  = (state_q == RESP) && !req_q.we;
  assign axil_req_o.b_ready  = (state_q == RESP) && req_q.we;

  assign aw_hs = axil_req_o.aw_valid && axil_rsp_i.aw_ready;
  assign w_hs  = axil_req_o.w_valid && axil_rsp_i.w_ready;
  assign ar_hs = axil_req_o.ar_valid && axil_rsp_i.ar_ready;

  assign rsp_valid_o = (axil_req_o.r_ready && axil_rsp_i.r_valid) ||
                       (axil_req_o.b_ready && axil_rsp_i.b_valid);
  assign rsp_o.rdata = axil_rsp_i.r_data;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: if (req_valid_i) state_q <= ADDR;
        ADDR: begin
          if (req_q.we) begin
            // AW and W may complete in either order
            if ((aw_done_q || aw_hs) && (w_done_q || w_hs)) begin
              aw_done_q <= 1'b0;
              w_done_q  <= 1'b0;
              state_q   <= RESP;
            end else begin
              aw_done_q <= aw_done_q | aw_hs;
              w_done_q  <= w_done_q | w_hs;
            end
          end else if (ar_hs) begin
            state_q <= RESP;
          end
        end
        RESP: if (rsp_valid_o) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      req_q <= req_i;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_req_o.ar_valid && !axil_rsp_i.ar_ready
    |=> axil_req_o.ar_valid && $stable(axil_req_o.ar_addr));

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_req_o.aw_valid && !axil_rsp_i.aw_ready
    |=> axil_req_o.aw_valid && $stable(axil_req_o.aw_addr));

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_req_o.w_valid && !axil_rsp_i.w_ready
    |=> axil_req_o.w_valid && $stable(axil_req_o.w_data));

endmodule

// ==== dma_cluster_top.sv ====
/*
 * single-channel cluster DMA
 * control port, transfer engine, window router and SoC master
 */

`timescale 1ns/100ps
`include "dma_defines.svh"

module dma_cluster_top import dma_ctrl_pkg::*; import dma_bus_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [5:0]             cluster_id_i,
  input  ctrl_req_t              ctrl_req_i,
  output ctrl_rsp_t              ctrl_rsp_o,
  output tcdm_req_t              tcdm_req_o,
  input  logic                   tcdm_gnt_i,
  input  logic [`DMA_DATA_W-1:0] tcdm_rdata_i,
  output axil_req_t              axil_req_o,
  input  axil_rsp_t              axil_rsp_i,
  output logic                   busy_o,
  output logic                   term_irq_o
);

  transf_descr_t descr;
  logic          descr_valid, descr_ready, engine_busy;
  mem_req_t      mem_req, soc_req;
  mem_rsp_t      mem_rsp, soc_rsp;
  logic          mem_valid, mem_ready, rsp_valid;
  logic          soc_valid, soc_ready, soc_rsp_valid;

  dma_ctrl_regs i_ctrl_regs (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .ctrl_req_i    ( ctrl_req_i  ),
    .ctrl_rsp_o    ( ctrl_rsp_o  ),
    .descr_valid_o ( descr_valid ),
    .descr_ready_i ( descr_ready ),
    .descr_o       ( descr       ),
    .xfer_done_i   ( term_irq_o  ),
    .engine_busy_i ( engine_busy ),
    .busy_o        ( busy_o      )
  );

  dma_xfer_engine i_xfer_engine (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .descr_valid_i ( descr_valid ),
    .descr_ready_o ( descr_ready ),
    .descr_i       ( descr       ),
    .mem_valid_o   ( mem_valid   ),
    .mem_ready_i   ( mem_ready   ),
    .mem_req_o     ( mem_req     ),
    .rsp_valid_i   ( rsp_valid   ),
    .rsp_i         ( mem_rsp     ),
    .busy_o        ( engine_busy ),
    .done_o        ( term_irq_o  )
  );

  dma_addr_router i_addr_router (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .cluster_id_i    ( cluster_id_i  ),
    .mem_valid_i     ( mem_valid     ),
    .mem_ready_o     ( mem_ready     ),
    .mem_req_i       ( mem_req       ),
    .rsp_valid_o     ( rsp_valid     ),
    .rsp_o           ( mem_rsp       ),
    .tcdm_req_o      ( tcdm_req_o    ),
    .tcdm_gnt_i      ( tcdm_gnt_i    ),
    .tcdm_rdata_i    ( tcdm_rdata_i  ),
    .soc_valid_o     ( soc_valid     ),
    .soc_ready_i     ( soc_ready     ),
    .soc_req_o       ( soc_req       ),
    .soc_rsp_valid_i ( soc_rsp_valid ),
    .soc_rsp_i       ( soc_rsp       )
  );

  dma_soc_axil_master i_soc_master (
    .clk_i       ( clk_i         ),
    .rst_ni      ( rst_ni        ),
    .req_valid_i ( soc_valid     ),
    .req_ready_o ( soc_ready     ),
    .req_i       ( soc_req       ),
    .rsp_valid_o ( soc_rsp_valid ),
    .rsp_o       ( soc_rsp       ),
    .axil_req_o  ( axil_req_o    ),
    .axil_rsp_i  ( axil_rsp_i    )
  );

endmodule

// ==== dma_tb_mem_models.sv ====
/*
 * testbench memory models
 * TCDM with one-cycle read data and AXI4-Lite SoC memory, both with random stalls
 */

`timescale 1ns/100ps
`include "dma_defines.svh"

module tb_tcdm_mem import dma_bus_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  tcdm_req_t              tcdm_req_i,
  output logic                   gnt_o,
  output logic [`DMA_DATA_W-1:0] rdata_o
);

  logic [`DMA_DATA_W-1:0] mem [logic [`DMA_ADDR_W-1:0]];
  // 0 never stalls, 3 grants about one cycle in four
  int     stall = 0;
  int     accesses = 0;
  integer seed = 33998;
  logic   gnt_q = 1'b0;
  logic [`DMA_DATA_W-1:0] rdata_q = '0;

  assign gnt_o   = gnt_q;
  assign rdata_o = rdata_q;

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      gnt_q <= 1'b0;
    end else begin
      gnt_q <= (($random(seed) & 3) >= stall);
      if (tcdm_req_i.req && gnt_q) begin
        accesses = accesses + 1;
        if (!tcdm_req_i.wen) begin
          mem[tcdm_req_i.add] = byte_merge(read_word(tcdm_req_i.add), tcdm_req_i.wdata,
                                           tcdm_req_i.be);
        end else begin
          rdata_q <= read_word(tcdm_req_i.add);
        end
      end
    end
  end

  function automatic logic [`DMA_DATA_W-1:0] addr_fill(logic [`DMA_ADDR_W-1:0] a);
    return {a[15:0] ^ 16'h5a5a, a[31:16]};
  endfunction

  function automatic logic [`DMA_DATA_W-1:0] read_word(logic [`DMA_ADDR_W-1:0] a);
    return mem.exists(a) ? mem[a] : addr_fill(a);
  endfunction

  // only enabled bytes take the new data
  function automatic logic [`DMA_DATA_W-1:0] byte_merge(logic [`DMA_DATA_W-1:0] old_word,
                                                        logic [`DMA_DATA_W-1:0] new_word,
                                                        logic [`DMA_DATA_W/8-1:0] be);
    logic [`DMA_DATA_W-1:0] res;
    res = old_word;
    for (int i = 0; i < `DMA_DATA_W/8; i++) begin
      if (be[i]) res[8*i +: 8] = new_word[8*i +: 8];
    end
    return res;
  endfunction

endmodule

module tb_soc_axil_mem import dma_bus_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  axil_req_t axil_req_i,
  output axil_rsp_t axil_rsp_o
);

  logic [`DMA_DATA_W-1:0] mem [logic [`DMA_ADDR_W-1:0]];
  int        stall = 0;
  int        accesses = 0;
  integer    seed = 33998;
  axil_rsp_t rsp_q = '0;
  logic      r_pend = 1'b0;
  logic      aw_got = 1'b0;
  logic      w_got = 1'b0;
  logic [`DMA_ADDR_W-1:0]   aw_addr_q;
  logic [`DMA_DATA_W-1:0]   w_data_q;
  logic [`DMA_DATA_W/8-1:0] w_strb_q;

  assign axil_rsp_o = rsp_q;

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      rsp_q  <= '0;
      r_pend <= 1'b0;
      aw_got <= 1'b0;
      w_got  <= 1'b0;
    end else begin
      rsp_q.ar_ready <= (($random(seed) & 3) >= stall);
      rsp_q.aw_ready <= (($random(seed) & 3) >= stall) && !aw_got;
      rsp_q.w_ready  <= (($random(seed) & 3) >= stall) && !w_got;
      if (axil_req_i.ar_valid && rsp_q.ar_ready) begin
        accesses = accesses + 1;
        r_pend <= 1'b1;
        rsp_q.r_data <= read_word(axil_req_i.ar_addr);
      end
      // read data shows up after a random delay
      if (r_pend && !rsp_q.r_valid && (($random(seed) & 3) >= stall)) begin
        rsp_q.r_valid <= 1'b1;
        r_pend <= 1'b0;
      end
      if (rsp_q.r_valid && axil_req_i.r_ready) begin
        rsp_q.r_valid <= 1'b0;
      end
      if (axil_req_i.aw_valid && rsp_q.aw_ready) begin
        accesses = accesses + 1;
        aw_got    <= 1'b1;
        aw_addr_q <= axil_req_i.aw_addr;
      end
      if (axil_req_i.w_valid && rsp_q.w_ready) begin
        w_got    <= 1'b1;
        w_data_q <= axil_req_i.w_data;
        w_strb_q <= axil_req_i.w_strb;
      end
      if (aw_got && w_got && !rsp_q.b_valid) begin
        mem[aw_addr_q] = byte_merge(read_word(aw_addr_q), w_data_q, w_strb_q);
        rsp_q.b_valid <= 1'b1;
        aw_got <= 1'b0;
        w_got  <= 1'b0;
      end
      if (rsp_q.b_valid && axil_req_i.b_ready) begin
        rsp_q.b_valid <= 1'b0;
      end
    end
  end

  // differs from the TCDM fill at every address
  function automatic logic [`DMA_DATA_W-1:0] addr_fill(logic [`DMA_ADDR_W-1:0] a);
    return {a[15:0] ^ 16'h3c3c, ~a[31:16]};
  endfunction

  function automatic logic [`DMA_DATA_W-1:0] read_word(logic [`DMA_ADDR_W-1:0] a);
    return mem.exists(a) ? mem[a] : addr_fill(a);
  endfunction

  function automatic logic [`DMA_DATA_W-1:0] byte_merge(logic [`DMA_DATA_W-1:0] old_word,
                                                        logic [`DMA_DATA_W-1:0] new_word,
                                                        logic [`DMA_DATA_W/8-1:0] be);
    logic [`DMA_DATA_W-1:0] res;
    res = old_word;
    for (int i = 0; i < `DMA_DATA_W/8; i++) begin
      if (be[i]) res[8*i +: 8] = new_word[8*i +: 8];
    end
    return res;
  endfunction

endmodule

// ==== dma_cluster_tb.sv ====
/*
 * cluster DMA testbench
 * register access, window routing, queue back-pressure and completion checks
 */

`timescale 1ns/100ps
`include "dma_defines.svh"

module dma_cluster_tb import dma_ctrl_pkg::*; import dma_bus_pkg::*; ();

  localparam int TIMEOUT = 20000;

  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;
  logic [5:0] cluster_id_i = '0;
  ctrl_req_t ctrl_req_i = '0;
  ctrl_rsp_t ctrl_rsp_o;
  tcdm_req_t tcdm_req_o;
  logic tcdm_gnt_i;
  logic [`DMA_DATA_W-1:0] tcdm_rdata_i;
  axil_req_t axil_req_o;
  axil_rsp_t axil_rsp_i;
  logic busy_o, term_irq_o;

  logic [`DMA_DATA_W-1:0] tcdm_shadow [logic [`DMA_ADDR_W-1:0]];
  logic [`DMA_DATA_W-1:0] soc_shadow [logic [`DMA_ADDR_W-1:0]];
  transf_descr_t pending_q [$];
  int irq_cnt = 0;

  always #4 clk_i = ~clk_i;

  dma_cluster_top dut0 (.*);
  tb_tcdm_mem tcdm0 (.clk_i, .rst_ni, .tcdm_req_i(tcdm_req_o), .gnt_o(tcdm_gnt_i),
                     .rdata_o(tcdm_rdata_i));
  tb_soc_axil_mem soc0 (.clk_i, .rst_ni, .axil_req_i(axil_req_o), .axil_rsp_o(axil_rsp_i));

  task automatic stop_on_error(string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_word(string name, logic [`DMA_DATA_W-1:0] exp,
                            logic [`DMA_DATA_W-1:0] act);
    if (exp !== act) begin
      stop_on_error($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_status(string name, logic exp_busy, logic [7:0] exp_cnt,
                              logic [`DMA_DATA_W-1:0] act);
    logic [`DMA_DATA_W-1:0] exp;
    exp = {16'b0, exp_cnt, 7'b0, exp_busy};
    if (exp !== act) begin
      stop_on_error($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
    end
  endtask

  // read data only compared for reads
  task automatic check_ctrl_rsp(string name, ctrl_rsp_t exp, ctrl_rsp_t act, bit with_data);
    if (!with_data) exp.r_rdata = act.r_rdata;
    if (exp !== act) begin
      stop_on_error($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
    end
  endtask

  function automatic logic [`DMA_DATA_W-1:0] tcdm_fill(logic [`DMA_ADDR_W-1:0] a);
    return {a[15:0] ^ 16'h5a5a, a[31:16]};
  endfunction

  function automatic logic [`DMA_DATA_W-1:0] soc_fill(logic [`DMA_ADDR_W-1:0] a);
    return {a[15:0] ^ 16'h3c3c, ~a[31:16]};
  endfunction

  function automatic bit in_window(logic [`DMA_ADDR_W-1:0] a);
    logic [`DMA_ADDR_W-1:0] base;
    base = `DMA_CLUSTER_BASE + (32'(cluster_id_i) << `DMA_CLUSTER_SHIFT);
    return (a >= base) && (a < base + `DMA_TCDM_SIZE);
  endfunction

  function automatic logic [`DMA_DATA_W-1:0] shadow_read(logic [`DMA_ADDR_W-1:0] a);
    if (in_window(a)) return tcdm_shadow.exists(a) ? tcdm_shadow[a] : tcdm_fill(a);
    return soc_shadow.exists(a) ? soc_shadow[a] : soc_fill(a);
  endfunction

  function automatic logic [`DMA_DATA_W-1:0] model_read(logic [`DMA_ADDR_W-1:0] a);
    if (in_window(a)) return tcdm0.mem.exists(a) ? tcdm0.mem[a] : tcdm_fill(a);
    return soc0.mem.exists(a) ? soc0.mem[a] : soc_fill(a);
  endfunction

  // word by word copy, in the order the engine moves them
  function automatic void copy_ref(transf_descr_t d);
    logic [`DMA_ADDR_W-1:0] dst;
    for (int i = 0; i < d.len; i++) begin
      dst = d.dst + 4 * i;
      if (in_window(dst)) tcdm_shadow[dst] = shadow_read(d.src + 4 * i);
      else soc_shadow[dst] = shadow_read(d.src + 4 * i);
    end
  endfunction

  // each completion checks the oldest outstanding destination
  always @(negedge clk_i) begin
    transf_descr_t d;
    if (rst_ni && term_irq_o) begin
      irq_cnt = irq_cnt + 1;
      if (pending_q.size() == 0) stop_on_error("term_irq_o pulsed with no transfer outstanding");
      d = pending_q.pop_front();
      for (int i = 0; i < d.len; i++) begin
        check_word("completed destination", shadow_read(d.dst + 4 * i),
                   model_read(d.dst + 4 * i));
      end
    end
  end

  task automatic ctrl_access(input logic wen, input logic [7:0] add,
                             input logic [`DMA_DATA_W-1:0] wdata,
                             output logic [`DMA_DATA_W-1:0] rdata, output int waits,
                             output logic busy_at_gnt);
    ctrl_rsp_t exp;
    @(posedge clk_i);
    ctrl_req_i <= '{req: 1'b1, wen: wen, add: add, wdata: wdata};
    waits = 0;
    @(negedge clk_i);
    while (!ctrl_rsp_o.gnt) begin
      waits++;
      if (waits > TIMEOUT) stop_on_error("timed out waiting for the control port grant");
      @(negedge clk_i);
    end
    busy_at_gnt = busy_o;
    exp = '{gnt: 1'b1, r_valid: 1'b0, r_rdata: '0};
    check_ctrl_rsp("no r_valid in the grant cycle", exp, ctrl_rsp_o, 1'b0);
    @(posedge clk_i);
    ctrl_req_i <= '0;
    @(negedge clk_i);
    exp = '{gnt: 1'b0, r_valid: 1'b1, r_rdata: '0};
    check_ctrl_rsp("r_valid one cycle after grant", exp, ctrl_rsp_o, 1'b0);
    rdata = ctrl_rsp_o.r_rdata;
  endtask

  task automatic issue_copy(input logic [31:0] src, input logic [31:0] dst,
                            input logic [15:0] len, output int waits);
    logic [31:0] rd;
    logic b;
    int w;
    ctrl_access(1'b1, REG_SRC, src, rd, w, b);
    ctrl_access(1'b1, REG_DST, dst, rd, w, b);
    ctrl_access(1'b1, REG_LEN, 32'(len), rd, w, b);
    copy_ref('{src: src, dst: dst, len: len});
    pending_q.push_back('{src: src, dst: dst, len: len});
    ctrl_access(1'b1, REG_CMD, '0, rd, waits, b);
  endtask

  task automatic wait_idle(int exp_irqs);
    int n;
    n = 0;
    while (irq_cnt != exp_irqs || busy_o) begin
      n++;
      if (n > TIMEOUT) stop_on_error("timed out waiting for the transfers to complete");
      @(negedge clk_i);
    end
  endtask

  // each memory against its own shadow, whatever the window is now
  task automatic compare_mems(string name);
    foreach (tcdm_shadow[a]) begin
      check_word(name, tcdm_shadow[a], tcdm0.mem.exists(a) ? tcdm0.mem[a] : 'x);
    end
    foreach (soc_shadow[a]) begin
      check_word(name, soc_shadow[a], soc0.mem.exists(a) ? soc0.mem[a] : 'x);
    end
    foreach (tcdm0.mem[a]) begin
      check_word(name, tcdm_shadow.exists(a) ? tcdm_shadow[a] : 'x, tcdm0.mem[a]);
    end
    foreach (soc0.mem[a]) begin
      check_word(name, soc_shadow.exists(a) ? soc_shadow[a] : 'x, soc0.mem[a]);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni <= 1'b0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
  endtask

  initial begin
    logic [31:0] rd;
    logic b;
    int w;
    int acc_t, acc_s;
    apply_reset();
    check_word("reset outputs", '0, {busy_o, term_irq_o, ctrl_rsp_o.r_valid, tcdm_req_o.req,
               axil_req_o.ar_valid, axil_req_o.aw_valid, axil_req_o.w_valid});
    ctrl_access(1'b1, REG_SRC, 32'hcafe_0124, rd, w, b);
    ctrl_access(1'b0, REG_SRC, '0, rd, w, b);
    check_word("REG_SRC readback", 32'hcafe_0124, rd);

    issue_copy(32'h1000_0000, 32'h1000_0400, 16'd8, w);
    wait_idle(1);
    compare_mems("tcdm to tcdm copy");

    @(posedge clk_i);
    cluster_id_i <= 6'd3;
    @(negedge clk_i);
    // window of cluster 3 starts at 0x10c0_0000
    issue_copy(32'h10bf_fff0, 32'h10c0_0000, 16'd4, w);
    issue_copy(32'h10c0_0100, 32'h2000_0000, 16'd6, w);
    wait_idle(3);
    compare_mems("soc and tcdm copies");

    apply_reset();
    irq_cnt = 0;
    tcdm0.stall = 3;
    soc0.stall = 3;
    for (int k = 0; k < 6; k++) begin
      issue_copy((k % 2) ? 32'h10c0_1000 + 32'(k * 64) : 32'h3000_0000 + 32'(k * 64),
                 32'h10c0_2000 + 32'(k * 64), 16'd8, w);
      if (k == 5 && w == 0) stop_on_error("command grant was not withheld with a full queue");
    end
    wait_idle(6);
    compare_mems("queued copies");
    ctrl_access(1'b0, REG_STATUS, '0, rd, w, b);
    check_status("status after queued copies", 1'b0, 8'd6, rd);

    tcdm0.stall = 2;
    soc0.stall = 2;
    acc_t = tcdm0.accesses;
    acc_s = soc0.accesses;
    issue_copy(32'h10c0_3000, 32'h10c0_4000, 16'd0, w);
    wait_idle(7);
    check_word("len 0 accesses", 32'(acc_t + acc_s), 32'(tcdm0.accesses + soc0.accesses));
    issue_copy(32'h10c0_5000, 32'h10c0_6000, 16'd40, w);
    ctrl_access(1'b0, REG_STATUS, '0, rd, w, b);
    check_status("status while busy", 1'b1, 8'd7, rd);
    check_word("busy_o while copying", 32'd1, 32'(b));
    wait_idle(8);
    compare_mems("long copy");
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== dma_cluster.f ====
+incdir+.
dma_ctrl_pkg.sv
dma_bus_pkg.sv
dma_fifo.sv
dma_ctrl_regs.sv
dma_xfer_engine.sv
dma_addr_router.sv
dma_soc_axil_master.sv
dma_cluster_top.sv
dma_tb_mem_models.sv
dma_cluster_tb.sv
